/* hdl/cache_tile_pkg.sv */
// Cache tile package.
// Shared widths, typedefs, opcodes, FSM states and packet formats
// for the mesh memory tile.

package cache_tile_pkg;

  localparam int CACHE_SETS  = 16;
  localparam int MEM_WORDS   = 4096;
  localparam int COORD_W     = 4;
  localparam int DATA_W      = 32;
  localparam int MASK_W      = DATA_W / 8;
  localparam int MEM_ADDR_W  = $clog2(MEM_WORDS);
  localparam int WORD_ADDR_W = MEM_ADDR_W + 1; // Top bit selects tag space.
  localparam int INDEX_W     = $clog2(CACHE_SETS);
  localparam int TAG_W       = MEM_ADDR_W - INDEX_W;

  typedef logic [COORD_W-1:0]     coord_t;
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;
  typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;
  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [MASK_W-1:0]      mask_t;
  typedef logic [INDEX_W-1:0]     cache_index_t;
  typedef logic [TAG_W-1:0]       cache_tag_t;

  typedef enum logic [1:0] {
    LM,     // Load word.
    SM,     // Masked store.
    TAGLA,  // Tag load.
    TAGST   // Tag store.
  } cache_op_e;

  typedef enum logic [2:0] {
    IDLE,
    EVICT,
    FILL_REQ,
    FILL_WAIT,
    RESP
  } cache_state_e;

  // Request as it arrives on the network link.
  typedef struct packed {
    coord_t     dest_x;
    coord_t     dest_y;
    coord_t     src_x;
    coord_t     src_y;
    word_addr_t addr;
    logic       we;
    mask_t      mask;
    data_t      data;
  } link_req_s;

  typedef struct packed {
    coord_t dest_x;
    coord_t dest_y;
    data_t  data;
  } link_rsp_s;

  // Request after the destination filter.
  typedef struct packed {
    coord_t     src_x;
    coord_t     src_y;
    word_addr_t addr;
    logic       we;
    mask_t      mask;
    data_t      data;
  } ep_req_s;

  typedef struct packed {
    cache_op_e opcode;
    mem_addr_t addr;
    mask_t     mask;
    data_t     data;
  } cache_pkt_s;

endpackage

/* hdl/link_endpoint.sv */
// Network link endpoint.
// Drops packets not addressed to this tile, queues the rest in a
// two-entry FIFO and returns each response to its sender.

`timescale 1ns/10ps

module link_endpoint
  import cache_tile_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  coord_t    my_x_i,
  input  coord_t    my_y_i,
  input  link_req_s req_i,
  input  logic      req_v_i,
  output logic      req_ready_o,
  output link_rsp_s rsp_o,
  output logic      rsp_v_o,
  input  logic      rsp_ready_i,
  output ep_req_s   ep_req_o,
  output logic      ep_v_o,
  input  logic      ep_yumi_i,
  input  data_t     ret_data_i,
  input  logic      ret_v_i,
  output logic      ret_ready_o
);

  // Pointers carry a wrap bit above the one-bit slot index.
  logic [1:0] wr_ptr_r;
  logic [1:0] head_ptr_r;  // FIFO head, popped by the yumi.
  logic [1:0] src_ptr_r;   // Oldest request still owed a response.
  ep_req_s    req_mem [2];
  ep_req_s    in_req;
  link_rsp_s  rsp_r;
  logic       rsp_v_r;
  logic       ready_en_r;
  logic       dest_match;
  logic       src_full;
  logic       req_fire;
  logic       push;
  logic       ret_fire;

  assign dest_match = (req_i.dest_x == my_x_i) && (req_i.dest_y == my_y_i);

  // Source queue holds at least as many entries as the FIFO.
  assign src_full    = (wr_ptr_r[1] != src_ptr_r[1]) && (wr_ptr_r[0] == src_ptr_r[0]);
  assign req_ready_o = ready_en_r & ~src_full;
  assign req_fire    = req_v_i & req_ready_o;
  assign push        = req_fire & dest_match; // Misaddressed packets are consumed here.

  assign in_req = '{src_x: req_i.src_x,
                    src_y: req_i.src_y,
                    addr:  req_i.addr,
                    we:    req_i.we,
                    mask:  req_i.mask,
                    data:  req_i.data};

  assign ep_v_o   = (head_ptr_r != wr_ptr_r);
  assign ep_req_o = req_mem[head_ptr_r[0]];

  // Response slot refills when empty or draining this cycle.
  assign ret_ready_o = ~rsp_v_r | rsp_ready_i;
  assign ret_fire    = ret_v_i & ret_ready_o;

  assign rsp_o   = rsp_r;
  assign rsp_v_o = rsp_v_r;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_en_r <= 1'b0;
      wr_ptr_r   <= 2'd0;
      head_ptr_r <= 2'd0;
      src_ptr_r  <= 2'd0;
      rsp_v_r    <= 1'b0;
    end else begin
      ready_en_r <= 1'b1;
      if (push)
        wr_ptr_r <= wr_ptr_r + 2'd1;
      if (ep_yumi_i)
        head_ptr_r <= head_ptr_r + 2'd1;
      if (ret_fire)
        src_ptr_r <= src_ptr_r + 2'd1;
      if (ret_fire)
        rsp_v_r <= 1'b1;
      else if (rsp_ready_i)
        rsp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push)
      req_mem[wr_ptr_r[0]] <= in_req;
    if (ret_fire) begin
      // Cache answers in order, so the oldest source owns this word.
      rsp_r <= '{dest_x: req_mem[src_ptr_r[0]].src_x,
                 dest_y: req_mem[src_ptr_r[0]].src_y,
                 data:   ret_data_i};
    end
  end

endmodule

/* hdl/link_to_cache.sv */
// Endpoint to cache translator.
// Picks the cache opcode from the tag-space bit and write flag, and
// joins the valid/ready and yumi handshakes of both sides.

`timescale 1ns/10ps

module link_to_cache
  import cache_tile_pkg::*;
(
  input  ep_req_s    ep_req_i,
  input  logic       ep_v_i,
  output logic       ep_yumi_o,
  output cache_pkt_s cache_pkt_o,
  output logic       pkt_v_o,
  input  logic       pkt_ready_i,
  input  data_t      rd_data_i,
  input  logic       rd_v_i,
  output logic       rd_yumi_o,
  output data_t      ret_data_o,
  output logic       ret_v_o,
  input  logic       ret_ready_i
);

  logic tag_space;

  assign tag_space = ep_req_i.addr[MEM_ADDR_W];

  always_comb begin
    if (tag_space)
      cache_pkt_o.opcode = ep_req_i.we ? TAGST : TAGLA;
    else
      cache_pkt_o.opcode = ep_req_i.we ? SM : LM;
  end

  assign cache_pkt_o.addr = ep_req_i.addr[MEM_ADDR_W-1:0]; // Word address.
  assign cache_pkt_o.mask = ep_req_i.mask;
  assign cache_pkt_o.data = ep_req_i.data;

  // Request side.
  assign pkt_v_o   = ep_v_i;
  assign ep_yumi_o = ep_v_i & pkt_ready_i;

  // Response side.
  assign ret_data_o = rd_data_i;
  assign ret_v_o    = rd_v_i;
  assign rd_yumi_o  = rd_v_i & ret_ready_i;

endmodule

/* hdl/cache_core.sv */
// Direct-mapped write-back cache with one-word lines.
// Serves loads, masked stores, tag loads and tag stores, and
// evicts dirty victims to the backing memory on a miss.

`timescale 1ns/10ps

module cache_core
  import cache_tile_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  cache_pkt_s cache_pkt_i,
  input  logic       pkt_v_i,
  output logic       pkt_ready_o,
  output data_t      rd_data_o,
  output logic       rd_v_o,
  input  logic       rd_yumi_i,
  output logic       mem_en_o,
  output logic       mem_we_o,
  output mem_addr_t  mem_addr_o,
  output data_t      mem_wdata_o,
  input  data_t      mem_rdata_i
);

  cache_state_e            state_r;
  cache_state_e            state_next;
  logic                    ready_r;
  logic [CACHE_SETS-1:0]   valid_r;
  logic [CACHE_SETS-1:0]   dirty_r;
  cache_tag_t              tag_mem [CACHE_SETS];
  data_t                   data_mem [CACHE_SETS];
  cache_pkt_s              pkt_r;     // Packet held through a miss.
  data_t                   rd_data_r;
  cache_index_t            in_idx;
  cache_tag_t              in_tag;
  cache_index_t            r_idx;
  cache_tag_t              r_tag;
  logic                    accept;
  logic                    hit;
  logic                    fast;

  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w,
                                        input mask_t m);
    data_t res;
    res = old_w;
    for (int b = 0; b < MASK_W; b++) begin
      if (m[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  assign in_idx = cache_pkt_i.addr[INDEX_W-1:0];
  assign in_tag = cache_pkt_i.addr[MEM_ADDR_W-1:INDEX_W];
  assign r_idx  = pkt_r.addr[INDEX_W-1:0];
  assign r_tag  = pkt_r.addr[MEM_ADDR_W-1:INDEX_W];

  assign pkt_ready_o = ready_r;
  assign accept      = pkt_v_i & pkt_ready_o;
  assign hit         = valid_r[in_idx] && (tag_mem[in_idx] == in_tag);
  // Tag operations never go to memory.
  assign fast        = hit || (cache_pkt_i.opcode == TAGLA) || (cache_pkt_i.opcode == TAGST);

  assign rd_v_o    = (state_r == RESP);
  assign rd_data_o = rd_data_r;

  assign mem_en_o    = (state_r == EVICT) || (state_r == FILL_REQ);
  assign mem_we_o    = (state_r == EVICT);
  assign mem_addr_o  = (state_r == EVICT) ? {tag_mem[r_idx], r_idx} : pkt_r.addr;
  assign mem_wdata_o = data_mem[r_idx]; // Victim word.

  always_comb begin
    state_next = state_r;
    case (state_r)
      IDLE: begin
        if (accept) begin
          if (fast)
            state_next = RESP;
          else if (valid_r[in_idx] && dirty_r[in_idx])
            state_next = EVICT;
          else
            state_next = FILL_REQ;
        end
      end
      EVICT:     state_next = FILL_REQ;
      FILL_REQ:  state_next = FILL_WAIT;
      FILL_WAIT: state_next = RESP;
      RESP: begin
        if (rd_yumi_i)
          state_next = IDLE;
      end
      default:   state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= IDLE;
      ready_r <= 1'b0;
      valid_r <= '0;
      dirty_r <= '0;
    end else begin
      state_r <= state_next;
      ready_r <= (state_next == IDLE);
      if (accept && fast) begin
        case (cache_pkt_i.opcode)
          SM: dirty_r[in_idx] <= 1'b1;  // Store hit.
          TAGST: begin
            valid_r[in_idx] <= cache_pkt_i.data[DATA_W-1];
            dirty_r[in_idx] <= 1'b0;    // Line dropped without writeback.
          end
          default: ;
        endcase
      end
      if (state_r == FILL_WAIT) begin
        valid_r[r_idx] <= 1'b1;
        dirty_r[r_idx] <= (pkt_r.opcode == SM);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      pkt_r <= cache_pkt_i;
      case (cache_pkt_i.opcode)
        LM: rd_data_r <= data_mem[in_idx];
        SM: begin
          if (hit)
            data_mem[in_idx] <= merge_bytes(data_mem[in_idx], cache_pkt_i.data,
                                            cache_pkt_i.mask);
          rd_data_r <= '0;
        end
        TAGLA: rd_data_r <= {valid_r[in_idx], 23'd0, tag_mem[in_idx]};
        TAGST: begin
          tag_mem[in_idx] <= cache_pkt_i.data[TAG_W-1:0];
          rd_data_r       <= '0;
        end
        default: rd_data_r <= '0;
      endcase
    end
    if (state_r == FILL_WAIT) begin
      tag_mem[r_idx] <= r_tag;
      if (pkt_r.opcode == SM) begin
        data_mem[r_idx] <= merge_bytes(mem_rdata_i, pkt_r.data, pkt_r.mask);
        rd_data_r       <= '0;
      end else begin
        data_mem[r_idx] <= mem_rdata_i;
        rd_data_r       <= mem_rdata_i;
      end
    end
  end

endmodule

/* hdl/backing_mem.sv */
// Backing memory of the tile.
// Word-addressed single-port RAM with registered read data.

`timescale 1ns/10ps

module backing_mem
  import cache_tile_pkg::*;
(
  input  logic      clk_i,
  input  logic      mem_en_i,
  input  logic      mem_we_i,
  input  mem_addr_t mem_addr_i,
  input  data_t     mem_wdata_i,
  output data_t     mem_rdata_o
);

  data_t mem [MEM_WORDS];
  data_t rdata_r;

  // Read data appears one cycle after the enable.
  always_ff @(posedge clk_i) begin
    if (mem_en_i) begin
      if (mem_we_i)
        mem[mem_addr_i] <= mem_wdata_i;  // Whole-word write.
      else
        rdata_r <= mem[mem_addr_i];
    end
  end

  assign mem_rdata_o = rdata_r;

endmodule

/* hdl/cache_tile.sv */
// Memory tile of the mesh.
// Endpoint, request translator, write-back cache and backing memory.

`timescale 1ns/10ps

module cache_tile
  import cache_tile_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  coord_t    my_x_i,
  input  coord_t    my_y_i,
  input  link_req_s req_i,
  input  logic      req_v_i,
  output logic      req_ready_o,
  output link_rsp_s rsp_o,
  output logic      rsp_v_o,
  input  logic      rsp_ready_i
);

  ep_req_s    ep_req;
  logic       ep_v;
  logic       ep_yumi;
  cache_pkt_s cache_pkt;
  logic       pkt_v;
  logic       pkt_ready;
  data_t      rd_data;
  logic       rd_v;
  logic       rd_yumi;
  data_t      ret_data;
  logic       ret_v;
  logic       ret_ready;
  logic       mem_en;
  logic       mem_we;
  mem_addr_t  mem_addr;
  data_t      mem_wdata;
  data_t      mem_rdata;

  link_endpoint link_endpoint_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .my_x_i      (my_x_i),
    .my_y_i      (my_y_i),
    .req_i       (req_i),
    .req_v_i     (req_v_i),
    .req_ready_o (req_ready_o),
    .rsp_o       (rsp_o),
    .rsp_v_o     (rsp_v_o),
    .rsp_ready_i (rsp_ready_i),
    .ep_req_o    (ep_req),
    .ep_v_o      (ep_v),
    .ep_yumi_i   (ep_yumi),
    .ret_data_i  (ret_data),
    .ret_v_i     (ret_v),
    .ret_ready_o (ret_ready)
  );

  link_to_cache link_to_cache_inst (
    .ep_req_i    (ep_req),
    .ep_v_i      (ep_v),
    .ep_yumi_o   (ep_yumi),
    .cache_pkt_o (cache_pkt),
    .pkt_v_o     (pkt_v),
    .pkt_ready_i (pkt_ready),
    .rd_data_i   (rd_data),
    .rd_v_i      (rd_v),
    .rd_yumi_o   (rd_yumi),
    .ret_data_o  (ret_data),
    .ret_v_o     (ret_v),
    .ret_ready_i (ret_ready)
  );

  cache_core cache_core_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cache_pkt_i (cache_pkt),
    .pkt_v_i     (pkt_v),
    .pkt_ready_o (pkt_ready),
    .rd_data_o   (rd_data),
    .rd_v_o      (rd_v),
    .rd_yumi_i   (rd_yumi),
    .mem_en_o    (mem_en),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata)
  );

  backing_mem backing_mem_inst (
    .clk_i       (clk_i),
    .mem_en_i    (mem_en),
    .mem_we_i    (mem_we),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_rdata_o (mem_rdata)
  );

endmodule

/* verification/tb_clock_gen.sv */
// Testbench clock and reset.
// 20 ns clock, active-low reset released after 8 cycles.

`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam real HALF_PERIOD = 10.0;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;  // Released away from the active edge.
  end

endmodule

/* verification/cache_tile_tb.sv */
// Testbench for the mesh memory tile.
// Replays the request cases on the link, predicts each response with a
// cache and memory model, and checks order, data and destination.

`timescale 1ns/10ps

module cache_tile_tb
  import cache_tile_pkg::*;
();

  localparam coord_t MY_X       = 4'd3;
  localparam coord_t MY_Y       = 4'd5;
  localparam int     WAIT_LIMIT = 200;
  localparam int     MAX_CASES  = 64;

  logic      clk;
  logic      rst_n;
  coord_t    my_x;
  coord_t    my_y;
  link_req_s req;
  logic      req_v;
  logic      req_ready;
  link_rsp_s rsp;
  logic      rsp_v;
  logic      rsp_ready;

  // Case row: flag, we, tag space, address, mask, data.
  logic [59:0]           cases_mem [MAX_CASES];
  logic [CACHE_SETS-1:0] m_valid;
  logic [CACHE_SETS-1:0] m_dirty;
  cache_tag_t            m_tag [CACHE_SETS];
  data_t                 m_data [CACHE_SETS];
  data_t                 m_mem [MEM_WORDS];
  link_rsp_s             exp_q [$];  // Responses still owed, oldest first.

  tb_clock_gen tb_clock_gen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  cache_tile cache_tile_inst (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .my_x_i      (my_x),
    .my_y_i      (my_y),
    .req_i       (req),
    .req_v_i     (req_v),
    .req_ready_o (req_ready),
    .rsp_o       (rsp),
    .rsp_v_o     (rsp_v),
    .rsp_ready_i (rsp_ready)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want)
      fail_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, want));
  endtask

  function automatic data_t byte_enables(input mask_t m);
    data_t bits;
    bits = '0;
    for (int b = 0; b < MASK_W; b++)
      bits[8*b +: 8] = {8{m[b]}};
    return bits;
  endfunction

  task automatic clear_model();
    m_valid = '0;
    m_dirty = '0;
    for (int s = 0; s < CACHE_SETS; s++) begin
      m_tag[s]  = '0;
      m_data[s] = '0;
    end
    for (int a = 0; a < MEM_WORDS; a++)
      m_mem[a] = '0;
  endtask

  // Applies one accepted request to the model and gives the expected word.
  task automatic model_access(input logic we, input logic tag_sp, input mem_addr_t addr,
                              input mask_t mask, input data_t wdata, output data_t rdata);
    cache_index_t idx;
    cache_tag_t   tag;
    data_t        en;
    idx   = addr[INDEX_W-1:0];
    tag   = addr[MEM_ADDR_W-1:INDEX_W];
    en    = byte_enables(mask);
    rdata = '0;
    if (tag_sp) begin
      if (we) begin
        m_tag[idx]   = wdata[TAG_W-1:0];
        m_valid[idx] = wdata[DATA_W-1];
        m_dirty[idx] = 1'b0;  // Dirty word is lost.
      end else begin
        rdata = {m_valid[idx], {(DATA_W-TAG_W-1){1'b0}}, m_tag[idx]};
      end
    end else begin
      if (!(m_valid[idx] && (m_tag[idx] == tag))) begin
        if (m_valid[idx] && m_dirty[idx])
          m_mem[{m_tag[idx], idx}] = m_data[idx];  // Victim writeback.
        m_data[idx]  = m_mem[addr];
        m_tag[idx]   = tag;
        m_valid[idx] = 1'b1;
        m_dirty[idx] = 1'b0;
      end
      if (we) begin
        m_data[idx]  = (m_data[idx] & ~en) | (wdata & en);
        m_dirty[idx] = 1'b1;
      end else begin
        rdata = m_data[idx];
      end
    end
  endtask

  task automatic send_case(input int num);
    logic [59:0] row;
    logic        bad;
    logic        accepted;
    data_t       want_data;
    link_rsp_s   exp_rsp;
    int          waited;
    row = cases_mem[num];
    bad = row[56];
    @(negedge clk);
    req.dest_x = bad ? coord_t'(MY_X + 4'd1) : MY_X;
    req.dest_y = MY_Y;
    req.src_x  = coord_t'(num % 16);
    req.src_y  = coord_t'((num * 5 + 2) % 16);
    req.addr   = {row[48], row[47:36]};
    req.we     = row[52];
    req.mask   = row[35:32];
    req.data   = row[31:0];
    req_v      = 1'b1;
    accepted   = 1'b0;
    waited     = 0;
    while (!accepted) begin
      @(posedge clk);
      if (req_ready) begin
        accepted = 1'b1;
      end else begin
        waited++;
        if (waited >= WAIT_LIMIT)
          fail_run($sformatf("Request %0d was not accepted within %0d cycles", num, WAIT_LIMIT));
      end
    end
    if (!bad) begin
      model_access(req.we, req.addr[MEM_ADDR_W], req.addr[MEM_ADDR_W-1:0], req.mask,
                   req.data, want_data);
      exp_rsp.dest_x = req.src_x;
      exp_rsp.dest_y = req.src_y;
      exp_rsp.data   = want_data;
      exp_q.push_back(exp_rsp);
    end
  endtask

  // Random response back-pressure.
  initial begin
    int seed;
    seed = 49;
    void'($urandom(seed));
    forever begin
      @(negedge clk);
      if (rst_n)
        rsp_ready = (($urandom % 3) != 0);
    end
  end

  initial begin
    link_rsp_s want;
    forever begin
      @(posedge clk);
      if (rst_n && rsp_v && rsp_ready) begin
        if (exp_q.size() == 0) begin
          fail_run("A response arrived with no request outstanding");
        end else begin
          want = exp_q.pop_front();
          check_value("rsp_o.data", rsp.data, want.data);
          check_value("rsp_o.dest_x", 32'(rsp.dest_x), 32'(want.dest_x));
          check_value("rsp_o.dest_y", 32'(rsp.dest_y), 32'(want.dest_y));
        end
      end
    end
  end

  initial begin
    int num_cases;
    int waited;
    req       = '0;
    req_v     = 1'b0;
    rsp_ready = 1'b0;
    my_x      = MY_X;
    my_y      = MY_Y;
    clear_model();
    $readmemh("verification/cache_tile_cases.txt", cases_mem);
    num_cases = 0;
    while ((num_cases < MAX_CASES) && !$isunknown(cases_mem[num_cases]) &&
           (cases_mem[num_cases][59:56] != 4'hf))
      num_cases++;
    if (num_cases == 0)
      fail_run("No request cases were read from the case file");
    waited = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited >= WAIT_LIMIT)
        fail_run("Reset was never released");
    end
    for (int i = 0; i < num_cases; i++)
      send_case(i);
    @(negedge clk);
    req_v = 1'b0;
    waited = 0;
    while ((exp_q.size() != 0) && (waited < WAIT_LIMIT)) begin
      @(negedge clk);
      waited++;
    end
    repeat (20) @(negedge clk);  // Catch any stray response.
    if (exp_q.size() == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      fail_run($sformatf("%0d responses never arrived", exp_q.size()));
    end
  end

endmodule

/* verification/cache_tile_cases.txt */
// Columns: flag_we_tagspace_addr_mask_data, all hex. Flag 1 marks a misaddressed
// packet and flag f ends the list. Index is addr[3:0], tag is addr[11:4].
0_1_0_010_f_11223344
0_1_0_010_5_00aa00bb
0_0_0_010_0_00000000
0_1_0_020_f_cafef00d
0_0_0_010_0_00000000
0_0_0_020_0_00000000
0_0_1_000_0_00000000
0_1_0_020_c_12340000
0_1_1_000_0_00000002
0_0_1_000_0_00000000
0_0_0_020_0_00000000
1_1_0_020_f_deadbeef
0_0_0_020_0_00000000
0_1_0_101_f_01010101
0_1_0_202_f_02020202
0_1_0_303_f_03030303
1_0_0_101_0_00000000
0_1_0_111_f_0a0b0c0d
0_0_0_101_0_00000000
0_1_0_202_3_0000ffee
0_0_0_202_0_00000000
0_0_0_111_0_00000000
0_0_1_001_0_00000000
0_0_0_303_0_00000000
0_1_0_313_f_13131313
0_0_0_303_0_00000000
0_0_0_313_0_00000000
f_0_0_000_0_00000000

/* sim.f */
hdl/cache_tile_pkg.sv
hdl/link_endpoint.sv
hdl/link_to_cache.sv
hdl/cache_core.sv
hdl/backing_mem.sv
hdl/cache_tile.sv
verification/tb_clock_gen.sv
verification/cache_tile_tb.sv
